//--- bench/issue_core_stim.txt
# T name | W pc word | F flush | R reg value
# pc, word and value in hex, reg in decimal
T alu_pairs
W 100 70800005
W 104 7100000c
W 108 71801ffd
W 10c 720007ff
W 110 12844000
W 114 23082000
W 118 538c8000
W 11c 64102000
W 120 348c4000
W 124 45044000
R 1 00000005
R 2 0000000c
R 3 fffffffd
R 4 000007ff
R 5 00000011
R 6 00000007
R 7 fffff802
R 8 0000ffe0
R 9 0000000c
R 10 0000000d
T mul_raw
W 200 75800007
W 204 76000009
W 208 86ad8000
W 20c 17356000
W 210 87b9a000
W 214 783c0001
R 13 0000003f
R 14 00000046
R 15 0000113a
R 16 0000113b
T waw
W 300 78800003
W 304 89462000
W 308 79000064
W 30c 19ca2000
R 18 00000064
R 19 00000067
T illegal
W 400 7a000015
W 404 fa000123
W 408 1ad28000
W 40c 8b528000
W 410 9a800000
R 20 00000015
R 21 0000002a
R 22 000001b9
T steering
W 700 7e000006
W 704 8ef38000
W 708 7f00000b
W 70c 8ffb8000
R 29 00000024
R 30 0000000b
R 31 00000042
T flush
W 500 7b800002
W 504 8c5ee000
W 508 8ce30000
W 50c 8d672000
W 510 8deb4000
F
W 600 7c000028
W 604 7c801fff
W 608 1d632000
W 60c 8deb0000
R 24 00000028
R 25 ffffffff
R 26 00000027
R 27 00000618

//--- bench/tb_clock.sv
// clock and reset generator for the issue core testbench
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_issue_core.sv
// testbench for the dual-issue core, replays stimulus programs and checks retired results
`default_nettype none

module tb_issue_core;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk, rst_n;
    logic flush = 1'b0;
    logic [31:0] inst0 = '0;
    logic [31:0] inst1 = '0;
    logic [31:0] pc = '0;
    logic [1:0] take;
    logic retire0_valid, retire1_valid;
    logic [31:0] retire0_pc, retire0_value, retire1_pc, retire1_value;
    logic [4:0] retire0_rd, retire1_rd;
    logic [3:0] retire0_exc;

    // parsed stimulus records
    string kind_q[$];
    string name_q[$];
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];

    // state of the running test
    string test_name;
    logic [31:0] seg_pc[$];
    logic [31:0] seg_word[$];
    int exp_reg[$];
    logic [31:0] exp_val[$];
    logic [31:0] word_at[logic [31:0]];
    int retired[logic [31:0]];
    bit flushed[logic [31:0]];
    logic [31:0] shadow [32];

    int cycle = 0;
    int quiet = 0;
    int flush_cycle = 0;
    int test_errs = 0;
    int total_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int watch_cycles = 0;
    bit in_test = 1'b0;

    tb_clock u_clk (.clk, .rst_n);

    issue_core i_dut (.*);

    always @(posedge clk)
        cycle <= cycle + 1;

    // check one retire against the program word at its PC, then update the shadow registers
    task automatic log_retire(input int port, input logic [31:0] rpc, input logic [4:0] rrd,
                              input logic [31:0] val, input logic [3:0] exc);
        logic [3:0] op;
        logic [3:0] want_exc;
        if (!word_at.exists(rpc)) begin
            $display("error: pc %h retired but is not part of test %s", rpc, test_name);
            test_errs++;
        end else begin
            op = word_at[rpc][31:28];
            // opcodes above 8 are illegal, 8 is mul
            want_exc = (op > 4'd8) ? 4'd1 : 4'd0;
            if (port == 1 && op >= 4'd8) begin
                $display("error: mul or illegal word at pc %h retired on port 1", rpc);
                test_errs++;
            end
            if (port == 0 && exc != want_exc) begin
                $display("FAIL %s exc at pc %h expected %0d actual %0d",
                         test_name, rpc, want_exc, exc);
                test_errs++;
            end
            if (flushed.exists(rpc) && cycle > flush_cycle + 2) begin
                $display("error: pc %h retired after the flush that cancelled it", rpc);
                test_errs++;
            end
            retired[rpc] = retired[rpc] + 1;
            if (exc == 4'd0 && rrd != 5'd0)
                shadow[rrd] = val;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (retire0_valid)
                log_retire(0, retire0_pc, retire0_rd, retire0_value, retire0_exc);
            if (retire1_valid)
                log_retire(1, retire1_pc, retire1_rd, retire1_value, 4'd0);
            quiet = (retire0_valid || retire1_valid) ? 0 : quiet + 1;
        end
    end

    task automatic read_stimulus();
        int fd;
        int n;
        int rnum;
        string tok;
        string nm;
        string line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/issue_core_stim.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open bench/issue_core_stim.txt");
            total_errs++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                nm = "";
                a = '0;
                b = '0;
                if (tok.getc(0) == "#") begin
                    n = $fgets(line, fd);
                end else begin
                    case (tok)
                        "T": n = $fscanf(fd, "%s", nm);
                        "W": n = $fscanf(fd, "%h %h", a, b);
                        "R": begin
                            n = $fscanf(fd, "%d %h", rnum, b);
                            a = rnum;
                        end
                        "F": n = 0;
                        default: begin
                            $display("error: unknown stimulus record %s", tok);
                            total_errs++;
                        end
                    endcase
                    kind_q.push_back(tok);
                    name_q.push_back(nm);
                    a_q.push_back(a);
                    b_q.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // fetch window model, take says how many words move on at the next edge
    task automatic feed_segment();
        int idx;
        idx = 0;
        while (idx < seg_pc.size()) begin
            @(posedge clk);
            #1;
            pc = seg_pc[idx];
            inst0 = seg_word[idx];
            inst1 = (idx + 1 < seg_pc.size()) ? seg_word[idx + 1] : '0;
            @(negedge clk);
            idx = idx + int'(take);
        end
        @(posedge clk);
        #1;
        inst0 = '0;
        inst1 = '0;
    endtask

    task automatic flush_pipeline();
        @(posedge clk);
        #1;
        flush = 1'b1;
        flush_cycle = cycle;
        foreach (seg_pc[i])
            flushed[seg_pc[i]] = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        seg_pc.delete();
        seg_word.delete();
    endtask

    // both units idle once nothing has retired for 8 cycles
    task automatic drain_units();
        quiet = 0;
        while (quiet < 8)
            @(posedge clk);
    endtask

    task automatic start_test(input string nm);
        test_name = nm;
        seg_pc.delete();
        seg_word.delete();
        exp_reg.delete();
        exp_val.delete();
        word_at.delete();
        retired.delete();
        flushed.delete();
        test_errs = 0;
        in_test = 1'b1;
    endtask

    task automatic end_test();
        feed_segment();
        drain_units();
        foreach (exp_reg[i]) begin
            if (shadow[exp_reg[i]] !== exp_val[i]) begin
                $display("FAIL %s r%0d expected %h actual %h",
                         test_name, exp_reg[i], exp_val[i], shadow[exp_reg[i]]);
                test_errs++;
            end
        end
        foreach (retired[p]) begin
            if (!flushed.exists(p) && word_at[p] != '0 && retired[p] != 1) begin
                $display("FAIL %s retires of pc %h expected 1 actual %0d",
                         test_name, p, retired[p]);
                test_errs++;
            end
        end
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d errors", test_name, test_errs);
            tests_failed++;
        end
        in_test = 1'b0;
    endtask

    initial begin
        foreach (shadow[i])
            shadow[i] = '0;
        read_stimulus();
        watch_cycles = 20 * kind_q.size() + 200;
        wait (rst_n === 1'b1);
        foreach (kind_q[i]) begin
            case (kind_q[i])
                "T": begin
                    if (in_test)
                        end_test();
                    start_test(name_q[i]);
                end
                "W": begin
                    seg_pc.push_back(a_q[i]);
                    seg_word.push_back(b_q[i]);
                    word_at[a_q[i]] = b_q[i];
                    retired[a_q[i]] = 0;
                end
                "F": begin
                    feed_segment();
                    flush_pipeline();
                end
                "R": begin
                    exp_reg.push_back(a_q[i]);
                    exp_val.push_back(b_q[i]);
                end
                default: ;
            endcase
        end
        if (in_test)
            end_test();
        $display("tests %0d failed %0d errors %0d", tests_run, tests_failed, total_errs);
        if (tests_run > 0 && tests_failed == 0 && total_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog sized from the stimulus length
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watch_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
// single-cycle ALU execution unit with a registered retire
`default_nettype none

module alu_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic en,
    input  issue_pkg::opcode_e op,
    input  logic [issue_pkg::xlen-1:0] a, b, imm,
    input  logic [issue_pkg::reg_idx_w-1:0] rd,
    input  logic [issue_pkg::xlen-1:0] pc,
    output logic ready,
    output logic finish,
    output logic [issue_pkg::reg_idx_w-1:0] done_rd,
    output logic [issue_pkg::xlen-1:0] result, retire_pc
);
    import issue_pkg::*;

    // never stalls
    assign ready = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            finish <= 1'b0;
        else
            finish <= en && !flush;
    end

    always_ff @(posedge clk) begin
        if (en) begin
            done_rd <= rd;
            retire_pc <= pc;
            result <= alu_calc(op, a, b, imm);
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_core.sv
// dual-issue core issue side with decoder, issue stage, register file and two units
`default_nettype none

module issue_core (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic [issue_pkg::xlen-1:0] inst0, inst1, pc,
    output logic [1:0] take,
    output logic retire0_valid, retire1_valid,
    output logic [issue_pkg::xlen-1:0] retire0_pc, retire0_value, retire1_pc, retire1_value,
    output logic [issue_pkg::reg_idx_w-1:0] retire0_rd, retire1_rd,
    output logic [issue_pkg::exc_w-1:0] retire0_exc
);
    import issue_pkg::*;

    opcode_e s0_op, s1_op, eu0_op, eu1_op;
    uop_class_e s0_class, s1_class, eu0_class;
    logic [reg_idx_w-1:0] s0_rd, s0_rj, s0_rk, s1_rd, s1_rj, s1_rk;
    logic [reg_idx_w-1:0] eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    logic [xlen-1:0] s0_imm, s1_imm, s0_pc, s1_pc;
    logic [xlen-1:0] eu0_imm, eu0_pc, eu1_imm, eu1_pc;
    logic [xlen-1:0] opa0, opb0, opa1, opb1;
    logic [exc_w-1:0] s0_exc, s1_exc, eu0_exc;
    logic s0_nop, s1_nop, eu0_en, eu1_en, eu0_ready, eu1_ready;
    logic wb0_en;

    // exception reports leave the register file alone
    assign wb0_en = retire0_valid && retire0_exc == exc_none;

    pair_decoder u_dec (.*);

    issue_stage u_issue (
        .*,
        .eu0_finish  (retire0_valid),
        .eu1_finish  (retire1_valid),
        .eu0_done_rd (retire0_rd),
        .eu1_done_rd (retire1_rd),
        .eu1_class   (),
        .eu1_exc     ()
    );

    reg_file u_rf (
        .clk, .rst_n,
        .ra0 (eu0_rj), .ra1 (eu0_rk), .ra2 (eu1_rj), .ra3 (eu1_rk),
        .we0 (wb0_en), .we1 (retire1_valid),
        .wa0 (retire0_rd), .wa1 (retire1_rd),
        .wd0 (retire0_value), .wd1 (retire1_value),
        .rd0 (opa0), .rd1 (opb0), .rd2 (opa1), .rd3 (opb1)
    );

    main_unit u_eu0 (
        .clk, .rst_n, .flush,
        .en (eu0_en), .op (eu0_op), .op_class (eu0_class),
        .a (opa0), .b (opb0), .imm (eu0_imm), .exc (eu0_exc),
        .rd (eu0_rd), .pc (eu0_pc), .ready (eu0_ready),
        .finish (retire0_valid), .done_rd (retire0_rd), .result (retire0_value),
        .retire_pc (retire0_pc), .retire_exc (retire0_exc)
    );

    alu_unit u_eu1 (
        .clk, .rst_n, .flush,
        .en (eu1_en), .op (eu1_op),
        .a (opa1), .b (opb1), .imm (eu1_imm),
        .rd (eu1_rd), .pc (eu1_pc), .ready (eu1_ready),
        .finish (retire1_valid), .done_rd (retire1_rd), .result (retire1_value),
        .retire_pc (retire1_pc)
    );

endmodule

`default_nettype wire

//--- hdl/issue_pkg.sv
// shared widths, instruction layout, opcode and class encodings for the dual-issue core
`default_nettype none

package issue_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;
    localparam int imm_w = 13;
    localparam int mul_latency = 3;
    localparam int op_w = 4;
    localparam int exc_w = 4;

    // instruction word layout
    localparam int op_lsb = 28;
    localparam int rd_lsb = 23;
    localparam int rj_lsb = 18;
    localparam int rk_lsb = 13;
    localparam int imm_lsb = 0;

    localparam logic [exc_w-1:0] exc_none = 4'd0;
    localparam logic [exc_w-1:0] exc_illegal = 4'd1;

    // encodings above op_mul are illegal
    typedef enum logic [op_w-1:0] {
        op_nop = 4'd0, op_add, op_sub, op_and, op_or,
        op_xor, op_sll, op_addi, op_mul
    } opcode_e;

    typedef enum logic [1:0] {
        class_none, class_alu, class_mul, class_exc
    } uop_class_e;

    // single-cycle ALU result, shared by both execution units
    function automatic logic [xlen-1:0] alu_calc(
        input opcode_e op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b,
        input logic [xlen-1:0] imm
    );
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_addi: return a + imm;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/issue_stage.sv
// in-order issue stage with a two-entry queue, register scoreboard and unit steering
`default_nettype none

module issue_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  issue_pkg::opcode_e s0_op, s1_op,
    input  issue_pkg::uop_class_e s0_class, s1_class,
    input  logic [issue_pkg::reg_idx_w-1:0] s0_rd, s0_rj, s0_rk, s1_rd, s1_rj, s1_rk,
    input  logic [issue_pkg::xlen-1:0] s0_imm, s1_imm, s0_pc, s1_pc,
    input  logic [issue_pkg::exc_w-1:0] s0_exc, s1_exc,
    input  logic s0_nop, s1_nop,
    input  logic eu0_ready, eu1_ready, eu0_finish, eu1_finish,
    input  logic [issue_pkg::reg_idx_w-1:0] eu0_done_rd, eu1_done_rd,
    output logic [1:0] take,
    output logic eu0_en, eu1_en,
    output issue_pkg::opcode_e eu0_op, eu1_op,
    output issue_pkg::uop_class_e eu0_class, eu1_class,
    output logic [issue_pkg::reg_idx_w-1:0] eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk,
    output logic [issue_pkg::xlen-1:0] eu0_imm, eu0_pc, eu1_imm, eu1_pc,
    output logic [issue_pkg::exc_w-1:0] eu0_exc, eu1_exc
);
    import issue_pkg::*;

    typedef struct packed {
        opcode_e op;
        uop_class_e cls;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rj;
        logic [reg_idx_w-1:0] rk;
        logic [xlen-1:0] imm;
        logic [exc_w-1:0] exc;
        logic [xlen-1:0] pc;
    } entry_t;

    entry_t q [2];
    entry_t in0, in1, eu0_ent, eu1_ent, nxt0, nxt1;
    logic [1:0] q_size, size_after, n_iss, n_valid, n_enq;
    logic [1:0] infl0, infl1;
    logic [reg_count-1:0] sb, sb_next;
    logic swap, go0, go1;

    // sources and destination must all be free
    function automatic logic regs_ok(input logic [reg_count-1:0] v, input entry_t e);
        return v[e.rj] && v[e.rk] && v[e.rd];
    endfunction

    assign in0 = '{op: s0_op, cls: s0_class, rd: s0_rd, rj: s0_rj, rk: s0_rk,
                   imm: s0_imm, exc: s0_exc, pc: s0_pc};
    assign in1 = '{op: s1_op, cls: s1_class, rd: s1_rd, rj: s1_rj, rk: s1_rk,
                   imm: s1_imm, exc: s1_exc, pc: s1_pc};

    // an ALU op at the head goes to eu1, leaving eu0 for the entry behind it
    assign swap = (q[0].cls == class_alu);

    always_comb begin
        sb_next = sb;
        // finishing results forward through the register file
        if (eu0_finish)
            sb_next[eu0_done_rd] = 1'b1;
        if (eu1_finish)
            sb_next[eu1_done_rd] = 1'b1;
        go0 = 1'b0;
        go1 = 1'b0;
        if (q_size != 2'd0 && regs_ok(sb_next, q[0]) && (swap ? eu1_ready : eu0_ready)) begin
            go0 = 1'b1;
            if (q[0].rd != '0)
                sb_next[q[0].rd] = 1'b0;
            if (q_size == 2'd2 && regs_ok(sb_next, q[1])
                    && (swap ? eu0_ready : (eu1_ready && q[1].cls == class_alu))) begin
                go1 = 1'b1;
                if (q[1].rd != '0)
                    sb_next[q[1].rd] = 1'b0;
            end
        end
    end

    assign eu0_ent = swap ? q[1] : q[0];
    assign eu1_ent = swap ? q[0] : q[1];
    assign eu0_en = swap ? go1 : go0;
    assign eu1_en = swap ? go0 : go1;

    assign eu0_op = eu0_ent.op;
    assign eu0_class = eu0_ent.cls;
    assign eu0_rd = eu0_ent.rd;
    assign eu0_rj = eu0_ent.rj;
    assign eu0_rk = eu0_ent.rk;
    assign eu0_imm = eu0_ent.imm;
    assign eu0_exc = eu0_ent.exc;
    assign eu0_pc = eu0_ent.pc;
    assign eu1_op = eu1_ent.op;
    assign eu1_class = eu1_ent.cls;
    assign eu1_rd = eu1_ent.rd;
    assign eu1_rj = eu1_ent.rj;
    assign eu1_rk = eu1_ent.rk;
    assign eu1_imm = eu1_ent.imm;
    assign eu1_exc = eu1_ent.exc;
    assign eu1_pc = eu1_ent.pc;

    assign n_iss = {1'b0, go0} + {1'b0, go1};
    assign size_after = q_size - n_iss;
    assign n_valid = {1'b0, !s0_nop} + {1'b0, !s1_nop};

    // nops are consumed without taking queue space
    always_comb begin
        case (size_after)
            2'd0:    take = 2'd2;
            2'd1:    take = (n_valid == 2'd2) ? 2'd1 : 2'd2;
            default: take = 2'd0;
        endcase
    end

    assign n_enq = (take == 2'd2) ? n_valid : take;

    // survivors shift to the head, new words land behind them
    always_comb begin
        nxt0 = go0 ? q[1] : q[0];
        nxt1 = q[1];
        if (size_after == 2'd0) begin
            nxt0 = in0;
            nxt1 = in1;
        end else if (size_after == 2'd1) begin
            nxt1 = in0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_size <= 2'd0;
            sb <= '1;
            infl0 <= 2'd0;
            infl1 <= 2'd0;
        end else if (flush) begin
            q_size <= 2'd0;
            sb <= '1;
            infl0 <= 2'd0;
            infl1 <= 2'd0;
        end else begin
            q_size <= size_after + n_enq;
            sb <= sb_next;
            infl0 <= infl0 + 2'(eu0_en) - 2'(eu0_finish);
            infl1 <= infl1 + 2'(eu1_en) - 2'(eu1_finish);
        end
    end

    always_ff @(posedge clk) begin
        q[0] <= nxt0;
        q[1] <= nxt1;
    end

    assert property (@(posedge clk) disable iff (!rst_n) take != 2'd3);
    assert property (@(posedge clk) disable iff (!rst_n) eu1_en |-> eu1_class != class_mul);
    assert property (@(posedge clk) disable iff (!rst_n)
        !(eu0_en && !eu0_ready) && !(eu1_en && !eu1_ready));
    // a unit never finishes work it was not given
    assert property (@(posedge clk) disable iff (!rst_n)
        !(eu0_finish && infl0 == 2'd0) && !(eu1_finish && infl1 == 2'd0));

endmodule

`default_nettype wire

//--- hdl/main_unit.sv
// general execution unit with ALU ops, a three-cycle multiply and exception reports
`default_nettype none

module main_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic en,
    input  issue_pkg::opcode_e op,
    input  issue_pkg::uop_class_e op_class,
    input  logic [issue_pkg::xlen-1:0] a, b, imm,
    input  logic [issue_pkg::exc_w-1:0] exc,
    input  logic [issue_pkg::reg_idx_w-1:0] rd,
    input  logic [issue_pkg::xlen-1:0] pc,
    output logic ready,
    output logic finish,
    output logic [issue_pkg::reg_idx_w-1:0] done_rd,
    output logic [issue_pkg::xlen-1:0] result, retire_pc,
    output logic [issue_pkg::exc_w-1:0] retire_exc
);
    import issue_pkg::*;

    typedef enum logic {
        idle,
        mul_busy
    } state_e;

    state_e state;
    logic [1:0] mul_cnt;
    logic [xlen-1:0] mul_prod;
    logic start, mul_start, mul_last;

    assign ready = (state == idle);
    assign start = en && ready;
    assign mul_start = start && op_class == class_mul;
    assign mul_last = (state == mul_busy) && (mul_cnt == 2'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            mul_cnt <= 2'd0;
            finish <= 1'b0;
        end else if (flush) begin
            // drops a multiply in flight
            state <= idle;
            mul_cnt <= 2'd0;
            finish <= 1'b0;
        end else begin
            finish <= mul_last || (start && !mul_start);
            if (mul_start) begin
                state <= mul_busy;
                mul_cnt <= 2'(mul_latency - 1);
            end else if (state == mul_busy) begin
                mul_cnt <= mul_cnt - 2'd1;
                if (mul_last)
                    state <= idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            done_rd <= rd;
            retire_pc <= pc;
            retire_exc <= exc;
            // exception reports carry no value
            result <= (op_class == class_alu) ? alu_calc(op, a, b, imm) : '0;
        end else if (mul_last) begin
            result <= mul_prod;
        end
        // low half only
        if (mul_start)
            mul_prod <= a * b;
    end

    assert property (@(posedge clk) disable iff (!rst_n) (state == mul_busy) |-> !en);

endmodule

`default_nettype wire

//--- hdl/pair_decoder.sv
// decodes the two-word fetch window into micro-op fields and compacts a leading nop
`default_nettype none

module pair_decoder (
    input  logic [issue_pkg::xlen-1:0] inst0, inst1, pc,
    output issue_pkg::opcode_e s0_op, s1_op,
    output issue_pkg::uop_class_e s0_class, s1_class,
    output logic [issue_pkg::reg_idx_w-1:0] s0_rd, s0_rj, s0_rk, s1_rd, s1_rj, s1_rk,
    output logic [issue_pkg::xlen-1:0] s0_imm, s1_imm, s0_pc, s1_pc,
    output logic [issue_pkg::exc_w-1:0] s0_exc, s1_exc,
    output logic s0_nop, s1_nop
);
    import issue_pkg::*;

    logic [xlen-1:0] word [2];
    opcode_e r_op [2];
    uop_class_e r_cls [2];
    logic [exc_w-1:0] r_exc [2];
    logic [reg_idx_w-1:0] r_rd [2];
    logic [reg_idx_w-1:0] r_rj [2];
    logic [reg_idx_w-1:0] r_rk [2];
    logic [xlen-1:0] r_imm [2];
    logic r_nop [2];
    logic [xlen-1:0] pc_hi;

    assign word[0] = inst0;
    assign word[1] = inst1;
    assign pc_hi = pc + xlen'(4);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            r_rd[i] = word[i][rd_lsb +: reg_idx_w];
            r_rj[i] = word[i][rj_lsb +: reg_idx_w];
            r_rk[i] = word[i][rk_lsb +: reg_idx_w];
            r_imm[i] = {{(xlen - imm_w){word[i][imm_lsb + imm_w - 1]}},
                        word[i][imm_lsb +: imm_w]};
            if (word[i][op_lsb +: op_w] > op_mul) begin
                // unknown opcode travels on as an exception report
                r_op[i] = op_nop;
                r_cls[i] = class_exc;
                r_exc[i] = exc_illegal;
            end else begin
                r_op[i] = opcode_e'(word[i][op_lsb +: op_w]);
                r_exc[i] = exc_none;
                case (r_op[i])
                    op_nop:  r_cls[i] = class_none;
                    op_mul:  r_cls[i] = class_mul;
                    default: r_cls[i] = class_alu;
                endcase
            end
            r_nop[i] = (r_cls[i] == class_none);
        end
    end

    // slot 1 moves up when slot 0 is empty
    assign s0_op = r_nop[0] ? r_op[1] : r_op[0];
    assign s0_class = r_nop[0] ? r_cls[1] : r_cls[0];
    assign s0_rd = r_nop[0] ? r_rd[1] : r_rd[0];
    assign s0_rj = r_nop[0] ? r_rj[1] : r_rj[0];
    assign s0_rk = r_nop[0] ? r_rk[1] : r_rk[0];
    assign s0_imm = r_nop[0] ? r_imm[1] : r_imm[0];
    assign s0_exc = r_nop[0] ? r_exc[1] : r_exc[0];
    assign s0_pc = r_nop[0] ? pc_hi : pc;
    assign s0_nop = r_nop[0] && r_nop[1];

    assign s1_op = r_nop[0] ? op_nop : r_op[1];
    assign s1_class = r_nop[0] ? class_none : r_cls[1];
    assign s1_rd = r_rd[1];
    assign s1_rj = r_rj[1];
    assign s1_rk = r_rk[1];
    assign s1_imm = r_imm[1];
    assign s1_exc = r_nop[0] ? exc_none : r_exc[1];
    assign s1_pc = pc_hi;
    assign s1_nop = r_nop[0] || r_nop[1];

    always_comb begin
        assert (!(s0_nop && s0_exc != exc_none) && !(s1_nop && s1_exc != exc_none))
            else $error("exception word marked as nop");
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// 32x32 register file, four read ports with write-through and two write ports
`default_nettype none

module reg_file (
    input  logic clk,
    input  logic rst_n,
    input  logic [issue_pkg::reg_idx_w-1:0] ra0, ra1, ra2, ra3,
    input  logic we0, we1,
    input  logic [issue_pkg::reg_idx_w-1:0] wa0, wa1,
    input  logic [issue_pkg::xlen-1:0] wd0, wd1,
    output logic [issue_pkg::xlen-1:0] rd0, rd1, rd2, rd3
);
    import issue_pkg::*;

    logic [xlen-1:0] mem [reg_count];

    // r0 is hardwired, port 1 has priority on a same-cycle write
    function automatic logic [xlen-1:0] read_port(input logic [reg_idx_w-1:0] ra);
        if (ra == '0)
            return '0;
        if (we1 && wa1 == ra)
            return wd1;
        if (we0 && wa0 == ra)
            return wd0;
        return mem[ra];
    endfunction

    always_comb begin
        rd0 = read_port(ra0);
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
        rd3 = read_port(ra3);
    end

    always_ff @(posedge clk) begin
        if (we0 && wa0 != '0)
            mem[wa0] <= wd0;
        if (we1 && wa1 != '0)
            mem[wa1] <= wd1;
    end

    // scoreboard keeps two live writers off the same register
    assert property (@(posedge clk) disable iff (!rst_n)
        !(we0 && we1 && wa0 == wa1 && wa0 != '0));

endmodule

`default_nettype wire

//--- issue_core.f
hdl/issue_pkg.sv
hdl/pair_decoder.sv
hdl/issue_stage.sv
hdl/reg_file.sv
hdl/alu_unit.sv
hdl/main_unit.sv
hdl/issue_core.sv
bench/tb_clock.sv
bench/tb_issue_core.sv
